/* common/fetch_pkg.sv */
package fetch_pkg;

	// ========================================
	// bundle geometry
	// ========================================

	// slots per fetched bundle
	localparam int fslots = 2;

	// instruction word address width
	localparam int addr_w = 16;

	// opcode and displacement fields of one word
	localparam int op_w = 8;
	localparam int disp_w = 8;

	// ========================================
	// opcodes seen by predecode
	// ========================================

	// jump-and-call, target is slot address plus displacement
	localparam logic [op_w-1:0] op_jc = 8'h20;

	// return through the link register
	localparam logic [op_w-1:0] op_rts = 8'h60;

	// conditional branch, taken when the slot hint is set
	localparam logic [op_w-1:0] op_bcc = 8'hd0;

	// one instruction word, opcode in the upper byte
	typedef struct packed {
		logic [op_w-1:0] op;
		logic signed [disp_w-1:0] disp;
	} slot_word_t;

endpackage

/* common/slot_if.sv */
`timescale 1ns/1ps

interface slot_if import fetch_pkg::*; ();

	// per-slot predecode flags
	logic [fslots-1:0] slot_jc;
	logic [fslots-1:0] slot_rts;
	logic [fslots-1:0] take_branch;

	// slots of the current bundle still visible to the queue
	logic [fslots-1:0] slotv;

	// queue takes, one or two slots, never both
	logic q1;
	logic q2;

	// redirect permission and the stomp of the remaining slots
	logic pc_override;
	logic stomp_next;

	modport pre (input slotv, output slot_jc, output slot_rts, output take_branch);
	modport sv (input slot_jc, input slot_rts, input take_branch, input q1, input q2,
		input pc_override, output slotv, output stomp_next);
	modport ctl (input slotv, input stomp_next, output q1, output q2, output pc_override);

endinterface

/* design/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic phit,
	input logic branchmiss,
	input logic q1,
	input logic q2,
	slot_if.ctl s,
	output logic nextb
);

	// set the cycle after an address change
	// ibundle still shows the old bundle then
	logic nextbd;

	// slots left over once this cycle's takes are done
	logic [fslots-1:0] left;

	// queue takes go onto the slot bus unchanged
	assign s.q1 = q1;
	assign s.q2 = q2;

	// ========================================
	// redirect permission
	// ========================================

	// bundle on ibundle is usable only with a hit
	// a miss or a stale cycle blocks any redirect
	assign s.pc_override = phit & ~branchmiss & ~nextbd;

	// single take drops the lowest visible slot
	always_comb begin
		if (q2)
			left = '0;
		else if (q1)
			left = s.slotv & (s.slotv - 1'b1);
		else
			left = s.slotv;
	end

	// ========================================
	// bundle advance
	// ========================================

	// advance when nothing is left, or when a taken control slot
	// was consumed and the rest of the bundle is stomped
	assign nextb = s.pc_override & (s.stomp_next | ~|left);

	// delayed strobe marking the stale bundle
	// reset makes the first cycle after reset stale as well
	always_ff @(posedge clk) begin
		if (rst)
			nextbd <= 1'b1;
		else
			nextbd <= nextb | branchmiss;
	end

	// queue never takes one and two slots at once
	a_q_onehot: assert property (@(posedge clk) disable iff (rst) !(q1 && q2));

endmodule

/* design/slot_valid.sv */
`timescale 1ns/1ps

module slot_valid import fetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic branchmiss,
	input logic nextb,
	input logic [fslots-1:0] pc_mask,
	slot_if.sv s
);

	// registered valid bits of the current bundle
	logic [fslots-1:0] slotvd;

	// slot holds a control transfer that will be taken
	logic [fslots-1:0] ctl;

	// valid slots up to and including the first control slot
	logic [fslots-1:0] vis;

	// start-slot mask widened to all slots from the start on
	logic [fslots-1:0] fill;

	// slots the queue takes this cycle
	logic [fslots-1:0] taken;

	assign ctl = s.slot_jc | s.slot_rts | s.take_branch;

	// ========================================
	// visible slots
	// ========================================

	// slots behind a taken control slot are wrong path
	// keep them away from the queue
	always_comb begin : hide
		logic blocked;
		blocked = 1'b0;
		for (int i = 0; i < fslots; i++) begin
			vis[i] = slotvd[i] & ~blocked;
			blocked = blocked | (slotvd[i] & ctl[i]);
		end
	end

	// nothing is visible without a usable bundle
	assign s.slotv = vis & {fslots{s.pc_override}};

	// q2 takes both, q1 the lowest visible slot
	always_comb begin
		if (s.q2)
			taken = s.slotv;
		else if (s.q1)
			taken = s.slotv & ~(s.slotv - 1'b1);
		else
			taken = '0;
	end

	// consumed control slot stomps what is left of the bundle
	assign s.stomp_next = s.pc_override & |(taken & ctl);

	// odd entry point leaves slot 0 invalid
	always_comb begin : expand
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < fslots; i++) begin
			seen = seen | pc_mask[i];
			fill[i] = seen;
		end
	end

	// ========================================
	// valid bit register
	// ========================================

	always_ff @(posedge clk) begin
		if (rst)
			// fetch restarts at address 0, which enters at slot 0
			slotvd <= '1;
		else if (branchmiss || nextb)
			slotvd <= fill;
		else if (s.pc_override)
			slotvd <= s.slotv & ~taken;
	end

	// valid bits only drop until the next bundle loads
	a_shrink: assert property (@(posedge clk) disable iff (rst)
		!(branchmiss || nextb) |=> (slotvd & ~$past(slotvd)) == '0);

	// a double take needs both slots on offer
	a_q2_both: assert property (@(posedge clk) disable iff (rst)
		s.q2 |-> &s.slotv);

endmodule

/* design/bundle_predecode.sv */
`timescale 1ns/1ps

module bundle_predecode import fetch_pkg::*; (
	input slot_word_t [fslots-1:0] ibundle,
	input logic [fslots-1:0] take_hint,
	input logic [addr_w-1:0] bundle_pc,
	input logic [addr_w-1:0] link,
	slot_if.pre s,
	output logic redirect,
	output logic [addr_w-1:0] target
);

	// word address of each slot
	logic [addr_w-1:0] slot_pc [fslots];

	// pc-relative target of each slot
	logic [addr_w-1:0] rel_tgt [fslots];

	// ========================================
	// per-slot classification
	// ========================================

	always_comb begin
		for (int i = 0; i < fslots; i++) begin
			s.slot_jc[i] = ibundle[i].op == op_jc;
			s.slot_rts[i] = ibundle[i].op == op_rts;
			// branch direction comes with the bundle
			s.take_branch[i] = (ibundle[i].op == op_bcc) & take_hint[i];
			// bundle base is even, slot index fills the low bit
			slot_pc[i] = {bundle_pc[addr_w-1:1], 1'(i)};
			// sign-extended displacement
			rel_tgt[i] = slot_pc[i] +
				{{(addr_w-disp_w){ibundle[i].disp[disp_w-1]}}, ibundle[i].disp};
		end
	end

	// ========================================
	// redirect select
	// ========================================

	// walk downward so the lowest valid control slot wins
	always_comb begin
		redirect = 1'b0;
		target = '0;
		for (int i = fslots - 1; i >= 0; i--) begin
			if (s.slotv[i] && (s.slot_jc[i] || s.slot_rts[i] || s.take_branch[i])) begin
				redirect = 1'b1;
				target = s.slot_rts[i] ? link : rel_tgt[i];
			end
		end
	end

endmodule

/* design/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic nextb,
	input logic redirect,
	input logic [addr_w-1:0] target,
	input logic jc_link_set,
	input logic [addr_w-1:0] jc_link_value,
	input logic branchmiss,
	input logic [addr_w-1:0] miss_pc,
	output logic [addr_w-1:0] fetch_pc,
	output logic [addr_w-1:0] bundle_pc,
	output logic [addr_w-1:0] link,
	output logic [fslots-1:0] pc_mask
);

	// first word of the following bundle
	logic [addr_w-1:0] seq_pc;

	// address taken on the next advance or miss
	logic [addr_w-1:0] next_pc;

	// an odd target still advances to the next even base
	assign seq_pc = {fetch_pc[addr_w-1:1] + 1'b1, 1'b0};

	// miss restart beats redirect, redirect beats fall-through
	always_comb begin
		if (branchmiss)
			next_pc = miss_pc;
		else if (redirect)
			next_pc = target;
		else
			next_pc = seq_pc;
	end

	// one-hot entry slot of the incoming bundle
	always_comb begin
		pc_mask = '0;
		pc_mask[next_pc[0]] = 1'b1;
	end

	// ========================================
	// address registers
	// ========================================

	// bundle_pc trails fetch_pc by the cache latency
	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_pc <= '0;
			bundle_pc <= '0;
		end else begin
			if (branchmiss || nextb)
				fetch_pc <= next_pc;
			bundle_pc <= fetch_pc;
		end
	end

	// single-entry return stack
	always_ff @(posedge clk) begin
		if (rst)
			link <= '0;
		else if (jc_link_set)
			link <= jc_link_value;
	end

endmodule

/* design/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic phit,
	input slot_word_t [fslots-1:0] ibundle,
	input logic [fslots-1:0] take_hint,
	input logic q1,
	input logic q2,
	input logic branchmiss,
	input logic [addr_w-1:0] miss_pc,
	output logic [addr_w-1:0] fetch_pc,
	output logic [addr_w-1:0] bundle_pc,
	output logic [fslots-1:0] slotv
);

	slot_if s ();

	logic nextb;
	logic redirect;
	logic [addr_w-1:0] target;
	logic [addr_w-1:0] link;
	logic [fslots-1:0] pc_mask;

	// slot 0 is the control slot behind a redirect
	logic ctl_slot0;
	logic jc_link_set;
	logic [addr_w-1:0] jc_link_value;

	// ========================================
	// link capture
	// ========================================

	assign ctl_slot0 = s.slotv[0] & (s.slot_jc[0] | s.slot_rts[0] | s.take_branch[0]);

	// a jump-and-call retiring with its bundle writes the link
	assign jc_link_set = nextb & (ctl_slot0 ? s.slot_jc[0] : s.slotv[1] & s.slot_jc[1]);

	// return address is the word after the call
	assign jc_link_value = {bundle_pc[addr_w-1:1], ~ctl_slot0} + 1'b1;

	fetch_ctrl u_ctrl (.clk(clk), .rst(rst), .phit(phit), .branchmiss(branchmiss),
		.q1(q1), .q2(q2), .s(s.ctl), .nextb(nextb));

	slot_valid u_slotv (.clk(clk), .rst(rst), .branchmiss(branchmiss), .nextb(nextb),
		.pc_mask(pc_mask), .s(s.sv));

	bundle_predecode u_pre (.ibundle(ibundle), .take_hint(take_hint), .bundle_pc(bundle_pc),
		.link(link), .s(s.pre), .redirect(redirect), .target(target));

	pc_gen u_pc (.clk(clk), .rst(rst), .nextb(nextb), .redirect(redirect), .target(target),
		.jc_link_set(jc_link_set), .jc_link_value(jc_link_value), .branchmiss(branchmiss),
		.miss_pc(miss_pc), .fetch_pc(fetch_pc), .bundle_pc(bundle_pc), .link(link),
		.pc_mask(pc_mask));

	assign slotv = s.slotv;

endmodule

/* tests/fetch_checker.sv */
`timescale 1ns/1ps

module fetch_checker import fetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic phit,
	input logic q1,
	input logic q2,
	input logic branchmiss,
	input logic [addr_w-1:0] miss_pc,
	input logic [addr_w-1:0] fetch_pc,
	input logic [addr_w-1:0] bundle_pc,
	input logic [fslots-1:0] slotv,
	output int mismatches,
	output int others,
	output int consumed
);

	// next address in program order
	logic [addr_w-1:0] exp_pc;

	// model of the one-entry link register
	logic [addr_w-1:0] link_m;

	// address the cache was given one cycle back
	logic [addr_w-1:0] fetch_d;

	initial begin
		mismatches = 0;
		others = 0;
		consumed = 0;
	end

	// ========================================
	// program order model
	// ========================================

	// one slot leaves the bundle for the queue
	task automatic consume(input logic [addr_w-1:0] a);
		logic [op_w+disp_w:0] w;
		logic [op_w-1:0] op;
		logic [addr_w-1:0] rel;
		// program words live in the testbench top with the hint in the top bit
		w = tb_fetch.prog[a[7:0]];
		op = w[op_w+disp_w-1:disp_w];
		rel = a + {{(addr_w-disp_w){w[disp_w-1]}}, w[disp_w-1:0]};
		consumed++;
		if (a !== exp_pc) begin
			mismatches++;
			$display("mismatch slot_addr at %0t: expected %h, got %h", $time, exp_pc, a);
		end
		// next expected address follows the consumed one
		if (op == op_jc) begin
			link_m = a + 1'b1;
			exp_pc = rel;
		end else if (op == op_rts)
			exp_pc = link_m;
		else if (op == op_bcc && w[op_w+disp_w])
			exp_pc = rel;
		else
			exp_pc = a + 1'b1;
	endtask

	// all values sampled here were set before this edge
	always @(posedge clk) begin : watch
		logic [fslots-1:0] take;
		logic found;
		take = '0;
		found = 1'b0;
		// bundle on ibundle belongs to the address presented last cycle
		if (!rst && bundle_pc !== fetch_d) begin
			mismatches++;
			$display("mismatch bundle_pc at %0t: expected %h, got %h", $time, fetch_d,
				bundle_pc);
		end
		fetch_d = fetch_pc;
		if (rst) begin
			exp_pc = '0;
			link_m = '0;
		end else if (branchmiss) begin
			if (slotv != '0) begin
				others++;
				$display("slots offered to the queue during a branch miss at %0t", $time);
			end
			// restart address comes first after the miss
			exp_pc = miss_pc;
		end else begin
			if (!phit && slotv != '0) begin
				others++;
				$display("slots offered to the queue while the cache missed at %0t", $time);
			end
			// single take uses the lowest valid slot
			if (q2)
				take = slotv;
			else if (q1) begin
				for (int i = 0; i < fslots; i++) begin
					if (slotv[i] && !found) begin
						take[i] = 1'b1;
						found = 1'b1;
					end
				end
			end
			for (int i = 0; i < fslots; i++)
				if (take[i])
					consume({bundle_pc[addr_w-1:1], 1'(i)});
		end
	end

endmodule

/* tests/tb_fetch.sv */
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*; ();

	logic clk;
	logic rst;
	logic phit;
	slot_word_t [fslots-1:0] ibundle;
	logic [fslots-1:0] take_hint;
	logic q1;
	logic q2;
	logic branchmiss;
	logic [addr_w-1:0] miss_pc;
	logic [addr_w-1:0] fetch_pc;
	logic [addr_w-1:0] bundle_pc;
	logic [fslots-1:0] slotv;

	int mismatches;
	int others;
	int consumed;
	int low_flow;
	logic [31:0] rnd;

	// program words by address with the take hint in bit 16
	logic [op_w+disp_w:0] prog [256];

	// queue acceptance per step as 0 none, 1 one slot or 2 two slots
	int accept [100] = '{
		1, 1, 2, 1, 0, 2, 1, 1, 1, 0, 2, 2, 1, 1, 0, 2, 1, 1, 2, 1,
		1, 0, 2, 1, 1, 1, 2, 0, 2, 1, 1, 1, 0, 1, 2, 1, 1, 0, 2, 1,
		1, 1, 1, 0, 2, 1, 2, 1, 1, 0, 2, 1, 1, 1, 1, 0, 2, 1, 1, 2,
		0, 2, 1, 1, 1, 1, 0, 2, 1, 1, 2, 1, 0, 1, 1, 2, 1, 1, 0, 2,
		1, 1, 1, 0, 2, 1, 1, 1, 2, 1, 1, 0, 2, 1, 1, 1, 0, 2, 1, 1
	};

	fetch_top u_dut (.clk(clk), .rst(rst), .phit(phit), .ibundle(ibundle),
		.take_hint(take_hint), .q1(q1), .q2(q2), .branchmiss(branchmiss),
		.miss_pc(miss_pc), .fetch_pc(fetch_pc), .bundle_pc(bundle_pc), .slotv(slotv));

	fetch_checker u_chk (.clk(clk), .rst(rst), .phit(phit), .q1(q1), .q2(q2),
		.branchmiss(branchmiss), .miss_pc(miss_pc), .fetch_pc(fetch_pc),
		.bundle_pc(bundle_pc), .slotv(slotv),
		.mismatches(mismatches), .others(others), .consumed(consumed));

	always #2 clk = ~clk;

	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic place(input int a, input logic [7:0] op, input logic [7:0] disp,
		input logic hint);
		prog[a] = {hint, op, disp};
	endtask

	// ========================================
	// one clock of cache and queue stimulus
	// ========================================

	task automatic cycle(input int code, input logic miss, input logic [addr_w-1:0] mpc);
		logic hit;
		logic pair_ok;
		logic [7:0] base;
		@(posedge clk);
		rnd = next_rand(rnd);
		hit = (rnd % 5) != 0;
		// both slots stay on offer if nothing was taken from a full bundle
		pair_ok = slotv == 2'b11 && !q1 && !q2 && hit && !miss;
		// cache answers the address presented last cycle
		base = {fetch_pc[7:1], 1'b0};
		phit <= hit;
		ibundle[0] <= prog[base][op_w+disp_w-1:0];
		ibundle[1] <= prog[base+1][op_w+disp_w-1:0];
		take_hint <= {prog[base+1][op_w+disp_w], prog[base][op_w+disp_w]};
		branchmiss <= miss;
		miss_pc <= mpc;
		// a double take that cannot be shown legal becomes a single one
		q1 <= !miss && (code == 1 || (code == 2 && !pair_ok));
		q2 <= !miss && code == 2 && pair_ok;
	endtask

	// run length bound of 20 cycles per table step
	initial begin
		#($size(accept) * 20 * 4);
		$display("watchdog expired before the acceptance table was done");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		phit = 1'b0;
		ibundle = '0;
		take_hint = '0;
		q1 = 1'b0;
		q2 = 1'b0;
		branchmiss = 1'b0;
		miss_pc = '0;
		low_flow = 0;
		rnd = 32'h9fef_7d53;

		// plain words everywhere since opcodes 10..1f are never control
		for (int a = 0; a < 256; a++)
			prog[a] = {1'b0, 8'h10 | 8'(a % 16), 8'(a) ^ 8'h5a};
		// call in slot 0 and a return from slot 1 into an odd entry
		place(6, op_jc, 8'd50, 1'b0);
		place(57, op_rts, 8'd0, 1'b0);
		// not-taken branch then a taken one to an odd target
		place(10, op_bcc, 8'd40, 1'b0);
		place(11, op_bcc, 8'd8, 1'b1);
		// call from slot 1
		place(21, op_jc, 8'd49, 1'b0);
		place(71, op_bcc, 8'd20, 1'b1);
		place(92, op_rts, 8'd0, 1'b0);
		place(28, op_bcc, 8'd72, 1'b1);
		// backward call closes a loop through the code above
		place(110, op_jc, 8'h9c, 1'b0);

		repeat (10)
			cycle(0, 1'b0, '0);
		rst <= 1'b0;

		for (int i = 0; i < $size(accept); i++) begin
			if (i == 70)
				cycle(0, 1'b1, 16'd150);
			else if (i == 85)
				cycle(0, 1'b1, 16'd133);
			else
				cycle(accept[i], 1'b0, '0);
		end
		repeat (4)
			cycle(0, 1'b0, '0);

		if (consumed < $size(accept) / 4) begin
			low_flow = 1;
			$display("too few slots reached the queue: %0d", consumed);
		end
		$display("checks done: %0d slots consumed, %0d mismatches, %0d other errors",
			consumed, mismatches, others + low_flow);
		if (mismatches == 0 && others + low_flow == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* build.f */
common/fetch_pkg.sv
common/slot_if.sv
design/fetch_ctrl.sv
design/slot_valid.sv
design/bundle_predecode.sv
design/pc_gen.sv
design/fetch_top.sv
tests/fetch_checker.sv
tests/tb_fetch.sv
